// ==== mpmc_pkg.sv ====
package mpmc_pkg;

	// ========================================
	// Sizes
	// ========================================

	// Width of one memory strip, the unit moved per app command
	localparam int STRIP_W = 128;

	// Strips in a full line
	localparam int LINE_STRIPS = 4;

	// Width of a full line and of a strip index within it
	localparam int LINE_W = STRIP_W * LINE_STRIPS;
	localparam int STRIP_IDX_W = $clog2(LINE_STRIPS);

	// Byte address; the low four bits are zero for a strip-aligned address
	localparam int ADDR_W = 28;

	// Tag carried by read requests back to the client
	localparam int TAG_W = 4;

	// Client ports feeding the arbiter
	localparam int NUM_PORTS = 2;

	// App command encodings as the memory interface expects them
	localparam logic [2:0] APP_CMD_WRITE = 3'd0;
	localparam logic [2:0] APP_CMD_READ = 3'd1;

	// ========================================
	// Types
	// ========================================

	// Controller states, shared by the sequencer and the enable generator
	typedef enum logic [2:0] {
		IDLE,
		WRITE_DATA0,
		WRITE_DATA1,
		WRITE_DATA2,
		READ_DATA0,
		READ_DATA1,
		READ_WAIT,
		DONE
	} mpmc_state_t;

	// A client request
	// num_strips holds the index of the last strip, so 0 means one strip
	// Strip n of the line sits at data[n*STRIP_W +: STRIP_W]
	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] addr;
		logic [5:0] num_strips;
		logic [TAG_W-1:0] tag;
		logic [LINE_W-1:0] data;
	} mpmc_req_t;

	// A read response returned to the port that asked for it
	typedef struct packed {
		logic port;
		logic [TAG_W-1:0] tag;
		logic [LINE_W-1:0] data;
	} mpmc_resp_t;

endpackage

// ==== mpmc_port_arbiter.sv ====
module mpmc_port_arbiter (
	input logic clk,
	input logic rst_n,
	input logic [mpmc_pkg::NUM_PORTS-1:0] req_valid,
	input mpmc_pkg::mpmc_req_t req [mpmc_pkg::NUM_PORTS],
	output logic [mpmc_pkg::NUM_PORTS-1:0] req_ready,
	output logic grant_valid,
	output logic grant_port,
	output mpmc_pkg::mpmc_req_t grant_req,
	input logic grant_ready
);

	import mpmc_pkg::*;

	// Port that gets first choice on the next grant
	logic prio_q;

	// ========================================
	// Winner selection
	// ========================================

	// The favoured port wins if it asks, otherwise the other one takes it
	// With only two ports this reduces to a single select bit
	always_comb
	begin
		if (req_valid[prio_q])
			grant_port = prio_q;
		else
			grant_port = ~prio_q;
	end

	assign grant_valid = |req_valid;
	assign grant_req = req[grant_port];

	// Only the winner sees the downstream ready
	always_comb
	begin
		req_ready = '0;
		req_ready[grant_port] = grant_valid & grant_ready;
	end

	// After a transfer, the port after the winner is favoured
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			prio_q <= 1'b0;
		else if (grant_valid && grant_ready)
			prio_q <= ~grant_port;
	end

	// A waiting client keeps its request raised and unchanged until it is taken
	for (genvar i = 0; i < NUM_PORTS; i++)
	begin : g_hold
		a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
			req_valid[i] && !req_ready[i] |=> req_valid[i] && $stable(req[i]));
	end

endmodule

// ==== mpmc_state_machine.sv ====
module mpmc_state_machine (
	input logic clk,
	input logic rst_n,
	input logic grant_valid,
	input logic grant_port,
	input mpmc_pkg::mpmc_req_t grant_req,
	output logic grant_ready,
	output mpmc_pkg::mpmc_state_t state,
	output logic [5:0] strip_cnt,
	output logic [5:0] num_strips,
	input logic app_en,
	input logic app_rdy,
	output logic [2:0] app_cmd,
	output logic [mpmc_pkg::ADDR_W-1:0] app_addr,
	output logic app_wdf_wren,
	output logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data,
	output logic start,
	output logic start_port,
	output logic [mpmc_pkg::TAG_W-1:0] start_tag,
	input logic line_done
);

	import mpmc_pkg::*;

	// Request in service and the port it came from
	mpmc_req_t req_q;
	logic port_q;

	// Set on the first clock out of reset so ready stays low during reset
	logic run_q;

	// Strip view of the write line
	logic [LINE_STRIPS-1:0][STRIP_W-1:0] wr_line;

	logic cmd_accept;
	logic last_strip;

	// The memory takes a command when enable and ready meet
	assign cmd_accept = app_en & app_rdy;
	assign last_strip = (strip_cnt == req_q.num_strips);

	// New work is only taken between requests
	assign grant_ready = run_q & (state == IDLE);

	// ========================================
	// Command outputs
	// ========================================

	// Address advances one strip (16 bytes) per accepted command
	assign app_cmd = req_q.we ? APP_CMD_WRITE : APP_CMD_READ;
	assign app_addr = req_q.addr + ADDR_W'({strip_cnt, 4'h0});
	assign num_strips = req_q.num_strips;

	// Write data goes out in the same cycle as its command, retried with it
	assign wr_line = req_q.data;
	assign app_wdf_data = wr_line[strip_cnt[STRIP_IDX_W-1:0]];
	assign app_wdf_wren = (state == WRITE_DATA2) & app_en;

	// Collector is armed as a read begins, before any command goes out
	assign start = (state == READ_DATA0);
	assign start_port = port_q;
	assign start_tag = req_q.tag;

	// Payload capture on the grant handshake
	always_ff @(posedge clk)
	begin
		if (grant_valid && grant_ready)
		begin
			req_q <= grant_req;
			port_q <= grant_port;
		end
	end

	// ========================================
	// Sequencing
	// ========================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			strip_cnt <= '0;
			run_q <= 1'b0;
		end
		else
		begin
			run_q <= 1'b1;
			case (state)
			IDLE:
				if (grant_valid && grant_ready)
				begin
					state <= grant_req.we ? WRITE_DATA0 : READ_DATA0;
					strip_cnt <= '0;
				end
			WRITE_DATA0:
				state <= WRITE_DATA1;
			WRITE_DATA1:
				state <= WRITE_DATA2;
			// Each write strip goes back through WRITE_DATA1 so enable re-arms
			WRITE_DATA2:
				if (cmd_accept)
				begin
					if (last_strip)
						state <= IDLE;
					else
					begin
						strip_cnt <= strip_cnt + 6'd1;
						state <= WRITE_DATA1;
					end
				end
			READ_DATA0:
				state <= READ_DATA1;
			// Reads stream back to back while the memory keeps accepting
			READ_DATA1:
				if (cmd_accept)
				begin
					if (last_strip)
						state <= READ_WAIT;
					else
						strip_cnt <= strip_cnt + 6'd1;
				end
			READ_WAIT:
				if (line_done)
					state <= DONE;
			DONE:
				state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end
	end

	// A refused command is repeated unchanged on the next cycle
	a_retry_stable: assert property (@(posedge clk) disable iff (!rst_n)
		app_en && !app_rdy |=> $stable(app_cmd) && $stable(app_addr));

endmodule

// ==== mpmc_app_en_gen.sv ====
module mpmc_app_en_gen (
	input logic clk,
	input logic rst_n,
	input mpmc_pkg::mpmc_state_t state,
	input logic rdy,
	input logic [5:0] strip_cnt,
	input logic [5:0] num_strips,
	output logic en
);

	import mpmc_pkg::*;

	// Enable trails the controller state by one clock
	// While the memory refuses, the strobe is raised again for a retry
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			en <= 1'b0;
		else
		begin
			en <= 1'b0;
			// First issue of a write strip
			if (state == WRITE_DATA1)
				en <= 1'b1;
			// Write strip still waiting on the memory
			else if (state == WRITE_DATA2 && !rdy)
				en <= 1'b1;
			// First read strip
			else if (state == READ_DATA0)
				en <= 1'b1;
			// Keep issuing reads until the last strip is taken
			else if (state == READ_DATA1 && !(rdy && strip_cnt == num_strips))
				en <= 1'b1;
		end
	end

endmodule

// ==== mpmc_read_collector.sv ====
module mpmc_read_collector (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic start_port,
	input logic [mpmc_pkg::TAG_W-1:0] start_tag,
	input logic [5:0] num_strips,
	input logic rd_valid,
	input logic [mpmc_pkg::STRIP_W-1:0] rd_data,
	output logic resp_valid,
	output mpmc_pkg::mpmc_resp_t resp,
	input logic resp_ready,
	output logic line_done
);

	import mpmc_pkg::*;

	// Line under assembly, strip n at index n
	logic [LINE_STRIPS-1:0][STRIP_W-1:0] line_q;

	// Owner of the read and how many strips it expects
	logic port_q;
	logic [TAG_W-1:0] tag_q;
	logic [5:0] last_q;

	// Index of the next strip to arrive
	logic [5:0] beat_cnt;

	// ========================================
	// Strip capture
	// ========================================

	// Payload registers take data as it arrives
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			port_q <= start_port;
			tag_q <= start_tag;
			last_q <= num_strips;
		end
		if (rd_valid)
			line_q[beat_cnt[STRIP_IDX_W-1:0]] <= rd_data;
	end

	// Response rises one clock after the last beat and holds until taken
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			beat_cnt <= '0;
			resp_valid <= 1'b0;
		end
		else
		begin
			if (start)
				beat_cnt <= '0;
			else if (rd_valid)
				beat_cnt <= beat_cnt + 6'd1;
			if (rd_valid && beat_cnt == last_q)
				resp_valid <= 1'b1;
			else if (resp_ready)
				resp_valid <= 1'b0;
		end
	end

	assign resp.port = port_q;
	assign resp.tag = tag_q;
	assign resp.data = line_q;

	// Tells the controller the read is fully retired
	assign line_done = resp_valid & resp_ready;

	// Only one read is in flight, so no beat can land on a held response
	a_no_beat_on_resp: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> !resp_valid);

endmodule

// ==== mpmc_top.sv ====
module mpmc_top (
	input logic clk,
	input logic rst_n,

	// Client request ports
	input logic [mpmc_pkg::NUM_PORTS-1:0] req_valid,
	output logic [mpmc_pkg::NUM_PORTS-1:0] req_ready,
	input mpmc_pkg::mpmc_req_t req [mpmc_pkg::NUM_PORTS],

	// Read responses
	output logic resp_valid,
	input logic resp_ready,
	output mpmc_pkg::mpmc_resp_t resp,

	// Memory app interface
	output logic app_en,
	output logic [2:0] app_cmd,
	output logic [mpmc_pkg::ADDR_W-1:0] app_addr,
	input logic app_rdy,
	output logic app_wdf_wren,
	output logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data,
	input logic app_rd_data_valid,
	input logic [mpmc_pkg::STRIP_W-1:0] app_rd_data
);

	import mpmc_pkg::*;

	// Arbiter to controller
	logic grant_valid;
	logic grant_ready;
	logic grant_port;
	mpmc_req_t grant_req;

	// Controller to enable generator and collector
	mpmc_state_t state;
	logic [5:0] strip_cnt;
	logic [5:0] num_strips;
	logic start;
	logic start_port;
	logic [TAG_W-1:0] start_tag;
	logic line_done;

	mpmc_port_arbiter u_arb (
		.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req),
		.req_ready(req_ready), .grant_valid(grant_valid), .grant_port(grant_port),
		.grant_req(grant_req), .grant_ready(grant_ready)
	);

	mpmc_state_machine u_fsm (
		.clk(clk), .rst_n(rst_n), .grant_valid(grant_valid), .grant_port(grant_port),
		.grant_req(grant_req), .grant_ready(grant_ready), .state(state),
		.strip_cnt(strip_cnt), .num_strips(num_strips), .app_en(app_en),
		.app_rdy(app_rdy), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data), .start(start),
		.start_port(start_port), .start_tag(start_tag), .line_done(line_done)
	);

	mpmc_app_en_gen u_en (
		.clk(clk), .rst_n(rst_n), .state(state), .rdy(app_rdy),
		.strip_cnt(strip_cnt), .num_strips(num_strips), .en(app_en)
	);

	mpmc_read_collector u_col (
		.clk(clk), .rst_n(rst_n), .start(start), .start_port(start_port),
		.start_tag(start_tag), .num_strips(num_strips), .rd_valid(app_rd_data_valid),
		.rd_data(app_rd_data), .resp_valid(resp_valid), .resp(resp),
		.resp_ready(resp_ready), .line_done(line_done)
	);

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model (
	input logic clk,
	input logic rst_n,
	input logic clr_cnt,
	input logic app_en,
	input logic [2:0] app_cmd,
	input logic [mpmc_pkg::ADDR_W-1:0] app_addr,
	output logic app_rdy,
	input logic app_wdf_wren,
	input logic [mpmc_pkg::STRIP_W-1:0] app_wdf_data,
	output logic app_rd_data_valid,
	output logic [mpmc_pkg::STRIP_W-1:0] app_rd_data
);

	timeunit 1ns;
	timeprecision 100ps;

	import mpmc_pkg::*;

	// Sparse strip storage, keyed by byte address
	logic [STRIP_W-1:0] mem [logic [ADDR_W-1:0]];

	// Accepted commands per address, and in total since the last clear
	int accept_cnt [logic [ADDR_W-1:0]];
	int accept_total;

	// Read strips waiting to go back, oldest first, with the cycle each is due
	logic [STRIP_W-1:0] rd_q [$];
	int due_q [$];

	int cyc;
	int due;
	int last_due;
	int lat;
	integer seed;
	integer rnd;

	// Never-written strips read back as a pattern of their own address
	function automatic logic [STRIP_W-1:0] fill_pattern(logic [ADDR_W-1:0] a);
		return {4'hf, a, 4'he, ~a, 4'hd, a ^ 28'h5a5a5a5, 4'hc, a + 28'h0123456};
	endfunction

	initial
	begin
		seed = 74170;
		app_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		accept_total = 0;
		cyc = 0;
		last_due = 0;
		forever
		begin
			// ========================================
			// Drive phase just after the rising edge
			// ========================================
			@(posedge clk);
			#1;
			cyc++;
			// Refuse about a third of the cycles
			rnd = $random(seed);
			app_rdy = rst_n && (rnd[7:0] % 3 != 0);
			if (due_q.size() > 0 && due_q[0] <= cyc)
			begin
				app_rd_data_valid = 1'b1;
				app_rd_data = rd_q.pop_front();
				void'(due_q.pop_front());
			end
			else
				app_rd_data_valid = 1'b0;

			// ========================================
			// Sample phase at mid cycle where the DUT outputs are settled
			// ========================================
			@(negedge clk);
			if (clr_cnt)
			begin
				accept_cnt.delete();
				accept_total = 0;
			end
			// The command is taken on the next edge only if enable and ready meet
			if (rst_n && app_en && app_rdy)
			begin
				accept_total++;
				if (accept_cnt.exists(app_addr))
					accept_cnt[app_addr]++;
				else
					accept_cnt[app_addr] = 1;
				if (app_cmd == APP_CMD_WRITE)
				begin
					if (app_wdf_wren)
						mem[app_addr] = app_wdf_data;
				end
				else
				begin
					// Latency of two to five cycles, but strips stay in order
					rnd = $random(seed);
					lat = 2 + rnd[1:0];
					due = cyc + lat;
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					due_q.push_back(due);
					rd_q.push_back(mem.exists(app_addr) ? mem[app_addr] : fill_pattern(app_addr));
				end
			end
		end
	end

endmodule

// ==== tb_mpmc.sv ====
module tb_mpmc;

	timeunit 1ns;
	timeprecision 100ps;

	import mpmc_pkg::*;

	// Cycles any single wait may take before the run is abandoned
	localparam int WAIT_LIMIT = 200;

	localparam logic [ADDR_W-1:0] SINGLE_ADDR = 28'h0000400;
	localparam logic [ADDR_W-1:0] SWEEP_BASE = 28'h0001000;
	localparam logic [ADDR_W-1:0] HOLD_WR_ADDR = 28'h0002000;

	logic clk;
	logic rst_n;
	logic [NUM_PORTS-1:0] req_valid;
	logic [NUM_PORTS-1:0] req_ready;
	mpmc_req_t req [NUM_PORTS];
	logic resp_valid;
	logic resp_ready;
	mpmc_resp_t resp;
	logic app_en;
	logic [2:0] app_cmd;
	logic [ADDR_W-1:0] app_addr;
	logic app_rdy;
	logic app_wdf_wren;
	logic [STRIP_W-1:0] app_wdf_data;
	logic app_rd_data_valid;
	logic [STRIP_W-1:0] app_rd_data;
	logic clr_cnt;

	int err_cnt;
	int tests_run;
	int tests_failed;

	// Port the arbiter should favour on its next grant
	logic rr_next;

	// Responses in the order they came back
	mpmc_resp_t got_q [$];

	mpmc_top u_mpmc_top (.*);

	tb_mem_model u_mem (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// ========================================
	// Helpers
	// ========================================

	// Data written to a strip is a pattern of its own address
	function automatic logic [STRIP_W-1:0] strip_data(logic [ADDR_W-1:0] a);
		return {4'h1, a, 4'h2, ~a, 4'h3, a ^ 28'h9c3e5a1, 4'h4, a + 28'h0456789};
	endfunction

	function automatic mpmc_req_t make_req(logic we, logic [ADDR_W-1:0] addr, int last,
		logic [TAG_W-1:0] tag);
		mpmc_req_t r;
		int k;
		r.we = we;
		r.addr = addr;
		r.num_strips = 6'(last);
		r.tag = tag;
		r.data = '0;
		for (k = 0; k < LINE_STRIPS; k++)
			if (we)
				r.data[k*STRIP_W +: STRIP_W] = strip_data(addr + ADDR_W'(16 * k));
		return r;
	endfunction

	function automatic int count_of(logic [ADDR_W-1:0] a);
		if (u_mem.accept_cnt.exists(a))
			return u_mem.accept_cnt[a];
		return 0;
	endfunction

	task automatic check(input bit ok, input string msg);
		assert (ok)
		else
			$display("ERR %0t ns: %s", $time, msg);
		if (!ok)
			err_cnt++;
	endtask

	task automatic timed_out(input string what);
		$display("Timeout at %0t ns: %s did not happen within %0d cycles",
			$time, what, WAIT_LIMIT);
		$display("FAIL: see errors above");
		$finish;
	endtask

	// Inputs change a nanosecond after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_counts();
		step();
		clr_cnt = 1'b1;
		step();
		clr_cnt = 1'b0;
	endtask

	task automatic raise_req(input logic port, input mpmc_req_t r);
		req[port] = r;
		req_valid[port] = 1'b1;
	endtask

	// Ready is sampled mid cycle, so the transfer is on the following edge
	task automatic finish_handshake(input logic port);
		int n;
		n = 0;
		@(negedge clk);
		while (!req_ready[port])
		begin
			if (n == WAIT_LIMIT)
				timed_out($sformatf("request handshake on port %0d", port));
			n++;
			@(negedge clk);
		end
		step();
		req_valid[port] = 1'b0;
		rr_next = ~port;
	endtask

	task automatic send_req(input logic port, input mpmc_req_t r);
		raise_req(port, r);
		finish_handshake(port);
	endtask

	// A write is complete once the memory has taken all its strips
	task automatic wait_writes(input int cnt);
		int n;
		n = 0;
		step();
		while (u_mem.accept_total < cnt)
		begin
			if (n == WAIT_LIMIT)
				timed_out("write completion");
			n++;
			step();
		end
	endtask

	task automatic wait_resp(output mpmc_resp_t r);
		int n;
		n = 0;
		@(negedge clk);
		while (!resp_valid)
		begin
			if (n == WAIT_LIMIT)
				timed_out("read response");
			n++;
			@(negedge clk);
		end
		r = resp;
	endtask

	task automatic collect_resps(input int cnt);
		mpmc_resp_t r;
		int i;
		for (i = 0; i < cnt; i++)
		begin
			wait_resp(r);
			got_q.push_back(r);
		end
	endtask

	task automatic write_line(input logic port, input logic [ADDR_W-1:0] addr, input int last);
		clear_counts();
		send_req(port, make_req(1'b1, addr, last, '0));
		wait_writes(last + 1);
	endtask

	task automatic check_resp(input mpmc_resp_t r, input logic port, input logic [TAG_W-1:0] tag,
		input logic [ADDR_W-1:0] addr, input int last);
		int k;
		logic [STRIP_W-1:0] got;
		logic [STRIP_W-1:0] exp;
		check(r.port == port, $sformatf("response port %0d, expected %0d", r.port, port));
		check(r.tag == tag, $sformatf("response tag %h, expected %h", r.tag, tag));
		for (k = 0; k <= last; k++)
		begin
			got = r.data[k*STRIP_W +: STRIP_W];
			exp = strip_data(addr + ADDR_W'(16 * k));
			check(got === exp, $sformatf("strip %0d of %h is %h, expected %h", k, addr, got, exp));
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic idle_after_reset();
		int e0;
		int n;
		e0 = err_cnt;
		for (n = 0; n < 20; n++)
		begin
			@(negedge clk);
			check(app_en === 1'b0 && app_wdf_wren === 1'b0 && resp_valid === 1'b0,
				$sformatf("idle outputs en=%b wren=%b resp_valid=%b",
				app_en, app_wdf_wren, resp_valid));
		end
		finish_test("idle after reset", e0);
	endtask

	task automatic single_strip_roundtrip();
		int e0;
		mpmc_resp_t r;
		e0 = err_cnt;
		write_line(1'b0, SINGLE_ADDR, 0);
		send_req(1'b0, make_req(1'b0, SINGLE_ADDR, 0, 4'h5));
		wait_resp(r);
		check_resp(r, 1'b0, 4'h5, SINGLE_ADDR, 0);
		finish_test("single strip write and read", e0);
	endtask

	// Refusals must neither drop nor repeat a command
	task automatic strip_count_sweep();
		int e0;
		int n;
		int k;
		logic [ADDR_W-1:0] base;
		logic [TAG_W-1:0] tag;
		mpmc_resp_t r;
		e0 = err_cnt;
		for (n = 0; n < LINE_STRIPS; n++)
		begin
			base = SWEEP_BASE + ADDR_W'(n * 'h100);
			tag = TAG_W'(n + 8);
			write_line(1'b0, base, LINE_STRIPS - 1);
			clear_counts();
			send_req(1'b0, make_req(1'b0, base, n, tag));
			wait_resp(r);
			step();
			check_resp(r, 1'b0, tag, base, n);
			check(u_mem.accept_total == n + 1, $sformatf("%0d read commands for %0d strips",
				u_mem.accept_total, n + 1));
			for (k = 0; k <= n; k++)
				check(count_of(base + ADDR_W'(16 * k)) == 1, $sformatf("%0d commands at %h",
					count_of(base + ADDR_W'(16 * k)), base + ADDR_W'(16 * k)));
		end
		finish_test("strip count sweep", e0);
	endtask

	// Both ports ask together and the favoured port goes first
	task automatic round_robin_pairs();
		int e0;
		int pair;
		int i;
		logic first;
		logic p;
		e0 = err_cnt;
		for (pair = 0; pair < 2; pair++)
		begin
			step();
			first = rr_next;
			got_q.delete();
			fork
				send_req(1'b0, make_req(1'b0, SWEEP_BASE, 1, 4'h3));
				send_req(1'b1, make_req(1'b0, SWEEP_BASE + 28'h100, 1, 4'hc));
				collect_resps(2);
			join
			for (i = 0; i < 2; i++)
			begin
				p = (i == 0) ? first : ~first;
				check_resp(got_q[i], p, p ? 4'hc : 4'h3, p ? SWEEP_BASE + 28'h100 : SWEEP_BASE, 1);
			end
		end
		finish_test("round robin pairs", e0);
	endtask

	task automatic response_backpressure();
		int e0;
		int n;
		mpmc_resp_t held;
		e0 = err_cnt;
		step();
		resp_ready = 1'b0;
		send_req(1'b0, make_req(1'b0, SWEEP_BASE + 28'h200, 3, 4'h6));
		wait_resp(held);
		clear_counts();
		// A write from the other port must wait behind the held response
		raise_req(1'b1, make_req(1'b1, HOLD_WR_ADDR, 0, '0));
		for (n = 0; n < 20; n++)
		begin
			@(negedge clk);
			check(resp_valid === 1'b1, "resp_valid dropped under back-pressure");
			check(resp === held, "response changed under back-pressure");
			check(req_ready === '0, $sformatf("req_ready %b while response held", req_ready));
		end
		check_resp(held, 1'b0, 4'h6, SWEEP_BASE + 28'h200, 3);
		step();
		resp_ready = 1'b1;
		finish_handshake(1'b1);
		wait_writes(1);
		check(count_of(HOLD_WR_ADDR) == 1, $sformatf("%0d commands at %h after release",
			count_of(HOLD_WR_ADDR), HOLD_WR_ADDR));
		finish_test("response back-pressure", e0);
	endtask

	// ========================================
	// Sequence
	// ========================================

	initial
	begin
		rst_n = 1'b0;
		req_valid = '0;
		req[0] = '0;
		req[1] = '0;
		resp_ready = 1'b1;
		clr_cnt = 1'b0;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		// The arbiter starts out favouring port 0
		rr_next = 1'b0;
		repeat (10)
			@(posedge clk);
		#1;
		rst_n = 1'b1;

		idle_after_reset();
		single_strip_roundtrip();
		strip_count_sweep();
		round_robin_pairs();
		response_backpressure();

		$display("summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== project.f ====
mpmc_pkg.sv
mpmc_port_arbiter.sv
mpmc_state_machine.sv
mpmc_app_en_gen.sv
mpmc_read_collector.sv
mpmc_top.sv
tb_mem_model.sv
tb_mpmc.sv
